//--- hw/pcie_core_pkg.sv
/*
 * Shared widths and counts for the two-port transmit arbiter,
 * the bus-master check switch and the arbiter select union
 */
`default_nettype none

package pcie_core_pkg;

    // ------------------------------------------------------------
    // Port and requester counts
    // ------------------------------------------------------------
    localparam int NUM_PORTS      = 2;
    localparam int CHANS_PER_PORT = 8;
    localparam int NUM_REQ        = NUM_PORTS * CHANS_PER_PORT;

    // Channel index within one port, and flat requester index
    localparam int CHAN_W = $clog2(CHANS_PER_PORT);
    localparam int SEL_W  = $clog2(NUM_REQ);

    // ------------------------------------------------------------
    // Transmit stream and MSI field widths
    // ------------------------------------------------------------
    localparam int TX_DESC_W = 128;
    localparam int TX_DATA_W = 128;
    localparam int MSI_TC_W  = 3;
    localparam int MSI_NUM_W = 5;

    // When set, no new grant is issued while bus mastering is off
    localparam bit CHECK_BUS_MASTER_ENA = 1'b1;

    // ------------------------------------------------------------
    // Arbiter select register
    // ------------------------------------------------------------
    // The round-robin search walks the flat index
    // The stream mux only needs the port bit, the top bit of the index
    typedef union packed {
        logic [SEL_W-1:0] idx;
        struct packed {
            logic              port;
            logic [CHAN_W-1:0] chan;
        } pc;
    } arb_select_u;

endpackage

`default_nettype wire

//--- hw/tx_port_if.sv
/*
 * Transmit stream bundle of one application port, with a
 * driving modport for the source and a reading one for the arbiter
 */
`timescale 1ns/10ps
`default_nettype none

interface tx_port_if
    import pcie_core_pkg::*;
();

    // Plain levels, the core handshake stays outside this bundle
    logic                 req;
    logic [TX_DESC_W-1:0] desc;
    logic [TX_DATA_W-1:0] data;
    logic                 dfr;
    logic                 dv;
    logic                 err;

    // Whoever produces the stream
    modport src (output req, desc, data, dfr, dv, err);

    // The arbiter looks at both port streams through this view
    modport arb (input req, desc, data, dfr, dv, err);

endinterface

`default_nettype wire

//--- hw/tx_port_arbiter.sv
/*
 * One-level round-robin arbiter over the sixteen transmit-ready lines
 * of both ports, plus the mux that hands the granted port's stream to the core
 */
`timescale 1ns/10ps
`default_nettype none

module tx_port_arbiter
    import pcie_core_pkg::*;
(
    input  wire logic               clk_in,
    input  wire logic               hw_rstn,

    // Ready lines, port 0 in the low byte and port 1 in the high byte
    input  wire logic [NUM_REQ-1:0] req,

    // Conditions that allow a new decision
    input  wire logic               pci_tx_idle,
    input  wire logic               tx_mask,
    input  wire logic               tx_stream_ready,
    input  wire logic               bus_master_en,

    tx_port_if.arb                  port0,
    tx_port_if.arb                  port1,
    tx_port_if.src                  core,

    output logic [NUM_REQ-1:0]      grant
);

    // Current owner of the transmit path
    arb_select_u        sel_q;
    // Winner of the search for the next edge
    arb_select_u        next_sel;
    logic [SEL_W-1:0]   cand;
    logic               found;
    logic               arb_en;

    // ------------------------------------------------------------
    // Decision enable
    // ------------------------------------------------------------
    // A new owner is only picked while both DMA transmit paths are
    // quiet, so a packet in flight is never cut in two
    // The core mask and stream ready give back-pressure from the hard IP
    assign arb_en = pci_tx_idle && !tx_mask && tx_stream_ready &&
                    (bus_master_en || !CHECK_BUS_MASTER_ENA);

    // ------------------------------------------------------------
    // Round-robin search
    // ------------------------------------------------------------
    // Start one above the current owner and walk upwards, wrapping
    // The current owner itself comes last, at offset NUM_REQ
    always_comb begin
        next_sel = sel_q;
        found    = 1'b0;
        cand     = '0;
        for (int i = 1; i <= NUM_REQ; i++) begin
            // Truncation to SEL_W bits gives the wrap
            cand = SEL_W'(sel_q.idx + i);
            if (!found && req[cand]) begin
                next_sel.idx = cand;
                found        = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Select and grant registers
    // ------------------------------------------------------------
    // Both hold when the enable is low or nobody is requesting
    always_ff @(posedge clk_in) begin
        if (!hw_rstn) begin
            sel_q.idx <= '0;
            grant     <= '0;
        end else if (arb_en && found) begin
            sel_q <= next_sel;
            // One-hot copy of the select, fed back to the port logic
            grant <= {{(NUM_REQ-1){1'b0}}, 1'b1} << next_sel.idx;
        end
    end

    // ------------------------------------------------------------
    // Stream mux
    // ------------------------------------------------------------
    // Purely combinational, the channel field does not matter here
    // After reset the select is zero so port 0 drives the core
    assign core.req  = sel_q.pc.port ? port1.req  : port0.req;
    assign core.desc = sel_q.pc.port ? port1.desc : port0.desc;
    assign core.data = sel_q.pc.port ? port1.data : port0.data;
    assign core.dfr  = sel_q.pc.port ? port1.dfr  : port0.dfr;
    assign core.dv   = sel_q.pc.port ? port1.dv   : port0.dv;
    assign core.err  = sel_q.pc.port ? port1.err  : port0.err;

endmodule

`default_nettype wire

//--- hw/msi_merge.sv
/*
 * Registered merge of the two ports' MSI requests,
 * port 0 wins when both ask in the same cycle
 */
`timescale 1ns/10ps
`default_nettype none

module msi_merge
    import pcie_core_pkg::*;
(
    input  wire logic                 clk_in,
    input  wire logic                 hw_rstn,

    input  wire logic                 req_p0,
    input  wire logic                 req_p1,
    input  wire logic [MSI_TC_W-1:0]  tc_p0,
    input  wire logic [MSI_TC_W-1:0]  tc_p1,
    input  wire logic [MSI_NUM_W-1:0] num_p0,
    input  wire logic [MSI_NUM_W-1:0] num_p1,

    output logic                      msi_req,
    output logic [MSI_TC_W-1:0]       msi_tc,
    output logic [MSI_NUM_W-1:0]      msi_num
);

    // The request is a one-cycle delayed OR of both ports
    // Traffic class and vector come from the requesting port,
    // and stay put when neither port asks
    always_ff @(posedge clk_in) begin
        if (!hw_rstn) begin
            msi_req <= 1'b0;
            msi_tc  <= '0;
            msi_num <= '0;
        end else begin
            msi_req <= req_p0 | req_p1;
            if (req_p0) begin
                msi_tc  <= tc_p0;
                msi_num <= num_p0;
            end else if (req_p1) begin
                msi_tc  <= tc_p1;
                msi_num <= num_p1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pcie_port_arbiter_top.sv
/*
 * Top of the shared layer between two application ports and the
 * hard IP, with transmit arbiter, MSI merge and receive sideband ORs
 */
`timescale 1ns/10ps
`default_nettype none

module pcie_port_arbiter_top
    import pcie_core_pkg::*;
(
    input  wire logic                      clk_in,
    input  wire logic                      hw_rstn,

    // Core and configuration status
    input  wire logic                      bus_master_en,
    input  wire logic                      tx_mask,
    input  wire logic                      tx_stream_ready,
    input  wire logic                      dma_tx_idle_p0,
    input  wire logic                      dma_tx_idle_p1,

    // Port 0 transmit side and MSI
    input  wire logic [CHANS_PER_PORT-1:0] tx_rdy_p0,
    input  wire logic                      tx_req_p0,
    input  wire logic [TX_DESC_W-1:0]      tx_desc_p0,
    input  wire logic [TX_DATA_W-1:0]      tx_data_p0,
    input  wire logic                      tx_dfr_p0,
    input  wire logic                      tx_dv_p0,
    input  wire logic                      tx_err_p0,
    input  wire logic                      app_msi_req_p0,
    input  wire logic [MSI_TC_W-1:0]       app_msi_tc_p0,
    input  wire logic [MSI_NUM_W-1:0]      app_msi_num_p0,

    // Port 1 transmit side and MSI
    input  wire logic [CHANS_PER_PORT-1:0] tx_rdy_p1,
    input  wire logic                      tx_req_p1,
    input  wire logic [TX_DESC_W-1:0]      tx_desc_p1,
    input  wire logic [TX_DATA_W-1:0]      tx_data_p1,
    input  wire logic                      tx_dfr_p1,
    input  wire logic                      tx_dv_p1,
    input  wire logic                      tx_err_p1,
    input  wire logic                      app_msi_req_p1,
    input  wire logic [MSI_TC_W-1:0]       app_msi_tc_p1,
    input  wire logic [MSI_NUM_W-1:0]      app_msi_num_p1,

    // Receive sidebands of both ports
    input  wire logic                      rx_ack_p0,
    input  wire logic                      rx_ack_p1,
    input  wire logic                      rx_ws_p0,
    input  wire logic                      rx_ws_p1,
    input  wire logic                      rx_mask_p0,
    input  wire logic                      rx_mask_p1,
    input  wire logic                      app_int_sts_p0,
    input  wire logic                      app_int_sts_p1,

    // Towards the ports
    output logic [NUM_REQ-1:0]             arb_grant,
    output logic                           pci_tx_idle,

    // Towards the hard IP
    output logic                           tx_req,
    output logic [TX_DESC_W-1:0]           tx_desc,
    output logic [TX_DATA_W-1:0]           tx_data,
    output logic                           tx_dfr,
    output logic                           tx_dv,
    output logic                           tx_err,
    output logic                           app_msi_req,
    output logic [MSI_TC_W-1:0]            app_msi_tc,
    output logic [MSI_NUM_W-1:0]           app_msi_num,
    output logic                           rx_ack,
    output logic                           rx_ws,
    output logic                           rx_mask,
    output logic                           app_int_sts
);

    tx_port_if port0_if ();
    tx_port_if port1_if ();
    tx_port_if core_if ();

    // ------------------------------------------------------------
    // Bundle the port streams
    // ------------------------------------------------------------
    assign port0_if.req  = tx_req_p0;
    assign port0_if.desc = tx_desc_p0;
    assign port0_if.data = tx_data_p0;
    assign port0_if.dfr  = tx_dfr_p0;
    assign port0_if.dv   = tx_dv_p0;
    assign port0_if.err  = tx_err_p0;

    assign port1_if.req  = tx_req_p1;
    assign port1_if.desc = tx_desc_p1;
    assign port1_if.data = tx_data_p1;
    assign port1_if.dfr  = tx_dfr_p1;
    assign port1_if.dv   = tx_dv_p1;
    assign port1_if.err  = tx_err_p1;

    // The path counts as idle only when neither DMA engine is sending
    assign pci_tx_idle = dma_tx_idle_p0 & dma_tx_idle_p1;

    // Both ports' ready lines go in, port 1 above port 0
    tx_port_arbiter i_arbiter (
        .clk_in          (clk_in),
        .hw_rstn         (hw_rstn),
        .req             ({tx_rdy_p1, tx_rdy_p0}),
        .pci_tx_idle     (pci_tx_idle),
        .tx_mask         (tx_mask),
        .tx_stream_ready (tx_stream_ready),
        .bus_master_en   (bus_master_en),
        .port0           (port0_if),
        .port1           (port1_if),
        .core            (core_if),
        .grant           (arb_grant)
    );

    assign tx_req  = core_if.req;
    assign tx_desc = core_if.desc;
    assign tx_data = core_if.data;
    assign tx_dfr  = core_if.dfr;
    assign tx_dv   = core_if.dv;
    assign tx_err  = core_if.err;

    msi_merge i_msi_merge (
        .clk_in  (clk_in),
        .hw_rstn (hw_rstn),
        .req_p0  (app_msi_req_p0),
        .req_p1  (app_msi_req_p1),
        .tc_p0   (app_msi_tc_p0),
        .tc_p1   (app_msi_tc_p1),
        .num_p0  (app_msi_num_p0),
        .num_p1  (app_msi_num_p1),
        .msi_req (app_msi_req),
        .msi_tc  (app_msi_tc),
        .msi_num (app_msi_num)
    );

    // ------------------------------------------------------------
    // Receive sidebands
    // ------------------------------------------------------------
    // An idle port holds these low, so an OR lets either one speak
    assign rx_ack      = rx_ack_p0 | rx_ack_p1;
    assign rx_ws       = rx_ws_p0 | rx_ws_p1;
    assign rx_mask     = rx_mask_p0 | rx_mask_p1;
    assign app_int_sts = app_int_sts_p0 | app_int_sts_p1;

endmodule

`default_nettype wire

//--- dv/pcie_port_arbiter_assertions.sv
/*
 * Concurrent checks on the arbiter grant register,
 * and the bind that attaches them to every arbiter instance
 */
`timescale 1ns/10ps
`default_nettype none

module pcie_port_arbiter_assertions
    import pcie_core_pkg::*;
(
    input wire logic               clk_in,
    input wire logic               hw_rstn,
    input wire logic [NUM_REQ-1:0] req,
    input wire logic [NUM_REQ-1:0] grant,
    input wire logic               pci_tx_idle,
    input wire logic               tx_mask,
    input wire logic               tx_stream_ready,
    input wire logic               bus_master_en
);

    // ------------------------------------------------------------
    // Grant shape
    // ------------------------------------------------------------
    // At most one requester owns the transmit path
    a_grant_onehot: assert property (@(posedge clk_in) disable iff (!hw_rstn)
        $onehot0(grant))
        else $error("Arbiter grant has more than one bit set");

    // A new owner must have had its ready line up at the deciding edge
    a_grant_requested: assert property (@(posedge clk_in) disable iff (!hw_rstn)
        $changed(grant) |-> |(grant & $past(req)))
        else $error("Arbiter granted a requester whose ready line was low");

    // ------------------------------------------------------------
    // Back-pressure
    // ------------------------------------------------------------
    // Any one blocking condition at an edge freezes the owner for the next cycle
    a_grant_hold: assert property (@(posedge clk_in) disable iff (!hw_rstn)
        (tx_mask || !tx_stream_ready || !pci_tx_idle ||
         (CHECK_BUS_MASTER_ENA && !bus_master_en)) |=> $stable(grant))
        else $error("Arbiter grant moved while the decision enable was low");

endmodule

bind tx_port_arbiter pcie_port_arbiter_assertions i_assertions (
    .clk_in          (clk_in),
    .hw_rstn         (hw_rstn),
    .req             (req),
    .grant           (grant),
    .pci_tx_idle     (pci_tx_idle),
    .tx_mask         (tx_mask),
    .tx_stream_ready (tx_stream_ready),
    .bus_master_en   (bus_master_en)
);

`default_nettype wire

//--- dv/pcie_port_arbiter_tb.sv
/*
 * Testbench for the two-port transmit arbiter top with seeded random
 * stimulus, a reference model, typed compare tasks and a watchdog
 */
`timescale 1ns/10ps
`default_nettype none

module pcie_port_arbiter_tb
    import pcie_core_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES   = 2000;

    // DUT ports keep the top-level names so that .* connects them
    logic clk_in, hw_rstn, bus_master_en, tx_mask, tx_stream_ready;
    logic dma_tx_idle_p0, dma_tx_idle_p1;
    logic [CHANS_PER_PORT-1:0] tx_rdy_p0, tx_rdy_p1;
    logic tx_req_p0, tx_dfr_p0, tx_dv_p0, tx_err_p0;
    logic tx_req_p1, tx_dfr_p1, tx_dv_p1, tx_err_p1;
    logic [TX_DESC_W-1:0] tx_desc_p0, tx_desc_p1, tx_desc;
    logic [TX_DATA_W-1:0] tx_data_p0, tx_data_p1, tx_data;
    logic app_msi_req_p0, app_msi_req_p1, app_msi_req;
    logic [MSI_TC_W-1:0] app_msi_tc_p0, app_msi_tc_p1, app_msi_tc;
    logic [MSI_NUM_W-1:0] app_msi_num_p0, app_msi_num_p1, app_msi_num;
    logic rx_ack_p0, rx_ack_p1, rx_ws_p0, rx_ws_p1, rx_mask_p0, rx_mask_p1;
    logic app_int_sts_p0, app_int_sts_p1;
    logic [NUM_REQ-1:0] arb_grant;
    logic pci_tx_idle, tx_req, tx_dfr, tx_dv, tx_err;
    logic rx_ack, rx_ws, rx_mask, app_int_sts;

    // Reference model state
    arb_select_u          m_sel;
    logic [NUM_REQ-1:0]   m_grant;
    logic                 m_msi_req;
    logic [MSI_TC_W-1:0]  m_msi_tc;
    logic [MSI_NUM_W-1:0] m_msi_num;

    integer seed   = 94288;
    int     errors = 0;
    int     checks = 0;

    pcie_port_arbiter_top i_dut (.*);

    initial clk_in = 1'b0;
    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    // True with a chance of one in n
    function automatic logic one_in(input int n);
        return ($unsigned($random(seed)) % n) == 0;
    endfunction

    // Mask, ready, idle and bus master lean towards an open arbiter
    task automatic drive_inputs(input logic rstn);
        hw_rstn         = rstn;
        bus_master_en   = !one_in(16);
        tx_mask         = one_in(8);
        tx_stream_ready = !one_in(8);
        dma_tx_idle_p0  = !one_in(10);
        dma_tx_idle_p1  = !one_in(10);
        // Sparse ready lines make the wrapping search travel further
        tx_rdy_p0 = CHANS_PER_PORT'($random(seed) & $random(seed));
        tx_rdy_p1 = CHANS_PER_PORT'($random(seed) & $random(seed));
        {tx_req_p0, tx_dfr_p0, tx_dv_p0, tx_err_p0} = 4'($random(seed));
        {tx_req_p1, tx_dfr_p1, tx_dv_p1, tx_err_p1} = 4'($random(seed));
        tx_desc_p0 = {$random(seed), $random(seed), $random(seed), $random(seed)};
        tx_desc_p1 = {$random(seed), $random(seed), $random(seed), $random(seed)};
        tx_data_p0 = {$random(seed), $random(seed), $random(seed), $random(seed)};
        tx_data_p1 = {$random(seed), $random(seed), $random(seed), $random(seed)};
        app_msi_req_p0 = one_in(4);
        app_msi_req_p1 = one_in(4);
        app_msi_tc_p0  = MSI_TC_W'($random(seed));
        app_msi_tc_p1  = MSI_TC_W'($random(seed));
        app_msi_num_p0 = MSI_NUM_W'($random(seed));
        app_msi_num_p1 = MSI_NUM_W'($random(seed));
        {rx_ack_p0, rx_ack_p1, rx_ws_p0, rx_ws_p1} = 4'($random(seed));
        {rx_mask_p0, rx_mask_p1, app_int_sts_p0, app_int_sts_p1} = 4'($random(seed));
    endtask

    // ------------------------------------------------------------
    // Reference model, stepped once per rising edge
    // ------------------------------------------------------------
    task automatic update_model();
        logic               en;
        logic               hit;
        logic [NUM_REQ-1:0] req;
        int                 start;
        int                 idx;
        req   = {tx_rdy_p1, tx_rdy_p0};
        start = m_sel.idx;
        hit   = 1'b0;
        en    = dma_tx_idle_p0 && dma_tx_idle_p1 && !tx_mask && tx_stream_ready &&
                (bus_master_en || !CHECK_BUS_MASTER_ENA);
        if (!hw_rstn) begin
            m_sel.idx = '0;
            m_grant   = '0;
            m_msi_req = 1'b0;
            m_msi_tc  = '0;
            m_msi_num = '0;
        end else begin
            // First set request above the owner, wrapping back to it last
            for (int k = 1; k <= NUM_REQ && en; k++) begin
                idx = (start + k) % NUM_REQ;
                if (!hit && req[idx]) begin
                    hit          = 1'b1;
                    m_sel.idx    = SEL_W'(idx);
                    m_grant      = '0;
                    m_grant[idx] = 1'b1;
                end
            end
            m_msi_req = app_msi_req_p0 | app_msi_req_p1;
            if (app_msi_req_p0) begin
                m_msi_tc  = app_msi_tc_p0;
                m_msi_num = app_msi_num_p0;
            end else if (app_msi_req_p1) begin
                m_msi_tc  = app_msi_tc_p1;
                m_msi_num = app_msi_num_p1;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_grant(input logic [NUM_REQ-1:0] got, input logic [NUM_REQ-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: arb_grant is %h, expected %h", $time, got, exp);
        end
    endtask

    // The tx outputs must carry the stream of the port in the select
    task automatic check_select(input arb_select_u sel);
        logic [TX_DESC_W+TX_DATA_W+3:0] got;
        logic [TX_DESC_W+TX_DATA_W+3:0] exp;
        got = {tx_req, tx_desc, tx_data, tx_dfr, tx_dv, tx_err};
        if (sel.pc.port)
            exp = {tx_req_p1, tx_desc_p1, tx_data_p1, tx_dfr_p1, tx_dv_p1, tx_err_p1};
        else
            exp = {tx_req_p0, tx_desc_p0, tx_data_p0, tx_dfr_p0, tx_dv_p0, tx_err_p0};
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: tx stream differs from port %0d",
                     $time, sel.pc.port);
        end
    endtask

    task automatic check_msi(input logic req, input logic [MSI_TC_W-1:0] tc,
                             input logic [MSI_NUM_W-1:0] num);
        checks++;
        if ({req, tc, num} !== {m_msi_req, m_msi_tc, m_msi_num}) begin
            errors++;
            $display("CHECK FAILED at %0t ns: msi req/tc/num %b/%0d/%0d, expected %b/%0d/%0d",
                     $time, req, tc, num, m_msi_req, m_msi_tc, m_msi_num);
        end
    endtask

    // Order is rx_ack, rx_ws, rx_mask, app_int_sts, pci_tx_idle
    task automatic check_sideband(input logic [4:0] got, input logic [4:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: sidebands %b, expected %b", $time, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        drive_inputs(1'b0);
        for (int cyc = 0; cyc < RESET_CYCLES + NUM_CYCLES; cyc++) begin
            @(posedge clk_in);
            update_model();
            // Registered outputs have settled one ns after the edge
            #1;
            check_grant(arb_grant, m_grant);
            check_msi(app_msi_req, app_msi_tc, app_msi_num);
            #1;
            drive_inputs(cyc >= RESET_CYCLES - 1);
            #1;
            check_select(m_sel);
            check_sideband({rx_ack, rx_ws, rx_mask, app_int_sts, pci_tx_idle},
                           {rx_ack_p0 | rx_ack_p1, rx_ws_p0 | rx_ws_p1,
                            rx_mask_p0 | rx_mask_p1, app_int_sts_p0 | app_int_sts_p1,
                            dma_tx_idle_p0 & dma_tx_idle_p1});
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // Watchdog sized from the stimulus length plus a margin
    initial begin
        #((RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout: the stimulus did not complete in the expected time");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/pcie_core_pkg.sv
hw/tx_port_if.sv
hw/tx_port_arbiter.sv
hw/msi_merge.sv
hw/pcie_port_arbiter_top.sv
dv/pcie_port_arbiter_assertions.sv
dv/pcie_port_arbiter_tb.sv

//--- Bender.yml
package:
  name: pcie_port_arbiter

sources:
  - hw/pcie_core_pkg.sv
  - hw/tx_port_if.sv
  - hw/tx_port_arbiter.sv
  - hw/msi_merge.sv
  - hw/pcie_port_arbiter_top.sv
  - target: test
    files:
      - dv/pcie_port_arbiter_assertions.sv
      - dv/pcie_port_arbiter_tb.sv
